//--- noc_pkg.sv
/* NoC router shared definitions
   Flit format, channel vector type and sizing of the input unit */

package noc_pkg;

  // Sizing
  // --------------------
  localparam int RADIX  = 5;  // Output ports, one virtual channel each
  localparam int DEPTH  = 4;  // Flits per channel FIFO
  localparam int DATA_W = 16; // Flit payload width

  // FIFO occupancy counter must reach DEPTH itself
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Read and write pointer width
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Channel index width for the round-robin pointer
  localparam int VC_W = (RADIX > 1) ? $clog2(RADIX) : 1;

  // Highest channel index
  // so the first arbitration after reset starts at channel 0
  localparam logic [VC_W-1:0] LAST_VC = VC_W'(RADIX - 1);

  // Types
  // --------------------

  // One flit on the link
  // A packet is one or more flits, the last one has tail set
  typedef struct packed {
    logic              tail;  // Last flit of the packet
    logic [DATA_W-1:0] data;  // Payload
  } flit_t;

  // One bit per virtual channel
  // Used for one-hot valids, per-channel valids, enables and grants
  typedef logic [RADIX-1:0] vc_vec_t;

endpackage

//--- pkt_fifo.sv
/* Packet FIFO
   One virtual channel, a first-word fall-through flit buffer with a
   registered space-available enable toward the upstream router */
`timescale 1ns/1ps

module pkt_fifo (
  input  logic           clk,
  input  logic           i_arst_n,
  input  noc_pkg::flit_t i_flit,  // Flit from upstream
  input  logic           i_wr,    // Write strobe, already gated by o_en
  input  logic           i_rd,    // Pop strobe from the arbiter
  output noc_pkg::flit_t o_flit,  // Head flit, always visible
  output logic           o_val,   // FIFO holds at least one flit
  output logic           o_en     // Room for one more flit
);

  // Storage and pointers
  // --------------------
  noc_pkg::flit_t            mem [noc_pkg::DEPTH];  // Flit storage, no reset
  logic [noc_pkg::PTR_W-1:0] wr_ptr;
  logic [noc_pkg::PTR_W-1:0] rd_ptr;
  logic [noc_pkg::CNT_W-1:0] count;                 // Flits held
  logic [noc_pkg::CNT_W-1:0] count_nxt;             // Occupancy after this cycle

  // Circular pointer advance
  function automatic logic [noc_pkg::PTR_W-1:0] ptr_inc(
    input logic [noc_pkg::PTR_W-1:0] ptr
  );
    if (int'(ptr) == noc_pkg::DEPTH - 1) begin
      return '0;  // Wrap to the first slot
    end
    return ptr + 1'b1;
  endfunction

  // Occupancy after this cycle's write and pop
  always_comb begin
    count_nxt = count;
    case ({i_wr, i_rd})
      2'b10:   count_nxt = count + 1'b1;  // Write only
      2'b01:   count_nxt = count - 1'b1;  // Pop only
      default: count_nxt = count;         // Both or neither
    endcase
  end

  // Control state
  // --------------------
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      o_en   <= 1'b1;  // Empty after reset
    end else begin
      if (i_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (i_rd) rd_ptr <= ptr_inc(rd_ptr);
      count <= count_nxt;
      o_en  <= int'(count_nxt) < noc_pkg::DEPTH;  // Next cycle still has a free slot
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (i_wr) begin
      mem[wr_ptr] <= i_flit;
    end
  end

  // Head is read straight from storage
  assign o_flit = mem[rd_ptr];
  assign o_val  = (count != '0);

  // Checks
  // --------------------

  // Upstream gating must keep writes away from a full buffer
  a_no_overflow : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_wr |-> int'(count) < noc_pkg::DEPTH);

  // Arbiter pops only a channel that reports a flit
  a_no_underflow : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_rd |-> o_val);

endmodule

//--- virtual_channel.sv
/* Virtual channel bank
   One flit FIFO per output port, written by the one-hot upstream valid
   and read out toward the switch by the arbiter */
`timescale 1ns/1ps

module virtual_channel (
  input  logic             clk,
  input  logic             i_arst_n,

  // Upstream link
  // --------------------
  input  noc_pkg::flit_t   i_flit,      // Flit from upstream router
  input  noc_pkg::vc_vec_t i_flit_val,  // One-hot, names the output port and so the channel
  output logic             o_en,        // Space in the requested channel

  // Switch side
  // --------------------
  output noc_pkg::flit_t   o_flit,      // Head of the selected channel
  output noc_pkg::vc_vec_t o_flit_val,  // Per-channel not empty, to the arbiter
  input  noc_pkg::vc_vec_t i_en,        // Per-channel pop
  input  noc_pkg::vc_vec_t i_sel        // Granted channel, steers o_flit
);

  noc_pkg::flit_t   fifo_flit [noc_pkg::RADIX];  // Head of every FIFO
  noc_pkg::vc_vec_t fifo_en;                     // Per-FIFO space available
  noc_pkg::vc_vec_t fifo_wr;                     // Per-FIFO write strobe

  // Write only where upstream points and the FIFO has room
  assign fifo_wr = i_flit_val & fifo_en;

  // Channel FIFOs
  // --------------------
  for (genvar i = 0; i < noc_pkg::RADIX; i++) begin : g_vc
    pkt_fifo u_fifo (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_flit   (i_flit),         // Same flit offered to every channel
      .i_wr     (fifo_wr[i]),
      .i_rd     (i_en[i]),        // Pop from the arbiter
      .o_flit   (fifo_flit[i]),
      .o_val    (o_flit_val[i]),
      .o_en     (fifo_en[i])
    );
  end

  // Output and enable multiplexers
  // Both selects are one-hot, so at most one branch fires
  always_comb begin
    o_flit = '0;
    o_en   = 1'b1;  // Nothing requested, nothing refused
    for (int i = 0; i < noc_pkg::RADIX; i++) begin
      if (i_sel[i])      o_flit = fifo_flit[i];
      if (i_flit_val[i]) o_en   = fifo_en[i];
    end
  end

  // Checks
  // --------------------

  // Upstream names at most one channel
  a_val_onehot : assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0(i_flit_val));

  // Refused flit is held by upstream
  a_hold_on_stall : assert property (@(posedge clk) disable iff (!i_arst_n)
    (|i_flit_val && !o_en) |=> ($stable(i_flit_val) && $stable(i_flit)));

endmodule

//--- vc_arbiter.sv
/* Virtual channel arbiter
   Round-robin choice of one channel, held until the packet's tail flit
   has gone to the switch so packets never interleave */
`timescale 1ns/1ps

module vc_arbiter (
  input  logic             clk,
  input  logic             i_arst_n,
  input  noc_pkg::vc_vec_t i_val,       // Channels holding a flit
  input  logic             i_tail,      // Tail flag of the granted head flit
  input  logic             i_sw_ready,  // Switch accepts a flit
  output noc_pkg::vc_vec_t o_grant,     // Registered one-hot grant
  output noc_pkg::vc_vec_t o_pop        // Per-channel pop
);

  logic [noc_pkg::VC_W-1:0] last_idx;   // Last winner
  logic [noc_pkg::VC_W-1:0] win_idx;    // Next winner
  logic                     win_found;
  logic                     tail_xfer;  // Tail flit leaves this cycle

  // Transfer needs the switch and a flit in the granted channel
  assign o_pop     = o_grant & i_val & {noc_pkg::RADIX{i_sw_ready}};
  assign tail_xfer = (|o_pop) & i_tail;

  // Round-robin search
  // --------------------
  // Starts one past the last winner and wraps
  always_comb begin
    int idx;
    win_idx   = last_idx;
    win_found = 1'b0;
    for (int k = 1; k <= noc_pkg::RADIX; k++) begin
      idx = int'(last_idx) + k;
      if (idx >= noc_pkg::RADIX) idx = idx - noc_pkg::RADIX;
      if (!win_found && i_val[idx]) begin
        win_found = 1'b1;
        win_idx   = idx[noc_pkg::VC_W-1:0];
      end
    end
  end

  // Grant register, locked for the whole packet
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_grant  <= '0;
      last_idx <= noc_pkg::LAST_VC;  // Channel 0 wins first
    end else if (o_grant == '0) begin
      if (win_found) begin
        o_grant  <= noc_pkg::vc_vec_t'(1) << win_idx;
        last_idx <= win_idx;
      end
    end else if (tail_xfer) begin
      o_grant <= '0;  // Release after the tail
    end
  end

  // Checks
  // --------------------
  a_grant_onehot : assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0(o_grant));

  // Packet lock holds the grant until its tail transfers
  a_grant_locked : assert property (@(posedge clk) disable iff (!i_arst_n)
    (|o_grant && !tail_xfer) |=> $stable(o_grant));

endmodule

//--- input_unit.sv
/* NoC router input unit
   Virtual channel buffering of one router port and packet-locked
   selection of a channel toward the crossbar switch */
`timescale 1ns/1ps

module input_unit (
  input  logic             clk,
  input  logic             i_arst_n,

  // Upstream link
  input  noc_pkg::flit_t   i_flit,
  input  noc_pkg::vc_vec_t i_flit_val,  // One-hot requested output port
  output logic             o_en,        // Flit accepted when high with a valid

  // Switch link
  output noc_pkg::flit_t   o_flit,
  output logic             o_flit_val,
  output noc_pkg::vc_vec_t o_flit_vc,   // One-hot channel tag
  input  logic             i_sw_ready
);

  noc_pkg::flit_t   vc_flit;  // Head of the granted channel
  noc_pkg::vc_vec_t vc_val;   // Channels not empty
  noc_pkg::vc_vec_t vc_sel;   // Grant
  noc_pkg::vc_vec_t vc_pop;   // Pop toward the FIFOs

  virtual_channel u_vc (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_flit     (i_flit),
    .i_flit_val (i_flit_val),
    .o_en       (o_en),
    .o_flit     (vc_flit),
    .o_flit_val (vc_val),
    .i_en       (vc_pop),
    .i_sel      (vc_sel)
  );

  vc_arbiter u_arb (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_val      (vc_val),
    .i_tail     (vc_flit.tail),  // Ends the packet lock
    .i_sw_ready (i_sw_ready),
    .o_grant    (vc_sel),
    .o_pop      (vc_pop)
  );

  // Switch outputs
  assign o_flit     = vc_flit;
  assign o_flit_val = |(vc_sel & vc_val);  // Granted channel has a flit
  assign o_flit_vc  = vc_sel;

endmodule

//--- tb_clock_gen.sv
/* Testbench clock and reset source
   40 ns clock, reset held low over the first three rising edges */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;  // Half of the 40 ns period
  end

  initial begin
    o_arst_n = 1'b1;
    #5 o_arst_n = 1'b0;          // Asynchronous assert before the first edge
    repeat (3) @(posedge o_clk);
    o_arst_n <= 1'b1;            // Release on a rising edge
  end

endmodule

//--- input_unit_tb.sv
/* Input unit testbench
   Random and directed packets with per-channel scoreboards,
   checked by concurrent assertions on the switch and upstream links */
`timescale 1ns/1ps

module input_unit_tb;

  localparam int N_PKT     = 60;  // Random packets, 1 to 4 flits each
  localparam int MAX_FLITS = 2 * noc_pkg::RADIX * noc_pkg::DEPTH + noc_pkg::RADIX + 4 * N_PKT;
  localparam int LIMIT     = 40 * MAX_FLITS + 200;

  logic             clk;
  logic             arst_n;
  noc_pkg::flit_t   i_flit;
  noc_pkg::vc_vec_t i_flit_val;
  logic             o_en;
  noc_pkg::flit_t   o_flit;
  logic             o_flit_val;
  noc_pkg::vc_vec_t o_flit_vc;
  logic             i_sw_ready = 1'b0;

  noc_pkg::flit_t   exp_q [noc_pkg::RADIX][$];  // Expected flits per channel
  noc_pkg::flit_t   exp_head = '0;               // Front of the channel on o_flit_vc
  logic             exp_any  = 1'b0;
  logic             exp_en   = 1'b1;             // Room in the offered channel
  int               pending  = 0;                // Flits not yet at the switch
  int               errors   = 0;
  int               sent     = 0;
  int               received = 0;
  int               cycles   = 0;
  int               seq      = 0;                // Payload sequence number
  int               ready_mode = 0;              // 0 low, 1 high, 2 random
  integer           seed     = 25657;
  string            test_name = "reset";
  logic             after_rst;                   // First cycle after reset release
  logic             in_pkt;                      // Packet started but tail not yet out
  logic             fair_on  = 1'b0;
  logic             fair_have_prev;
  logic             end_chk  = 1'b0;
  noc_pkg::vc_vec_t lock_vc;                     // Channel of the packet in flight
  noc_pkg::vc_vec_t fair_prev;

  tb_clock_gen u_clk (.o_clk(clk), .o_arst_n(arst_n));

  input_unit dut (
    .clk        (clk),
    .i_arst_n   (arst_n),
    .i_flit     (i_flit),
    .i_flit_val (i_flit_val),
    .o_en       (o_en),
    .o_flit     (o_flit),
    .o_flit_val (o_flit_val),
    .o_flit_vc  (o_flit_vc),
    .i_sw_ready (i_sw_ready)
  );

  function automatic int onehot_to_index(input noc_pkg::vc_vec_t v);
    int idx;
    idx = 0;
    for (int i = 0; i < noc_pkg::RADIX; i++) if (v[i]) idx = i;
    return idx;
  endfunction

  // Next channel up in round-robin order
  function automatic noc_pkg::vc_vec_t rotate_up(input noc_pkg::vc_vec_t v);
    return {v[noc_pkg::RADIX-2:0], v[noc_pkg::RADIX-1]};
  endfunction

  // Scoreboard
  // --------------------
  always @(posedge clk or negedge arst_n) begin
    int wi;
    int ri;
    if (!arst_n) begin
      after_rst      <= 1'b1;
      in_pkt         <= 1'b0;
      lock_vc        <= '0;
      fair_prev      <= '0;
      fair_have_prev <= 1'b0;
    end else begin
      after_rst <= 1'b0;
      if (|i_flit_val && o_en) begin  // Accepted from upstream
        wi = onehot_to_index(i_flit_val);
        exp_q[wi].push_back(i_flit);
        sent++;
      end
      if (o_flit_val && i_sw_ready) begin  // Taken by the switch
        ri = onehot_to_index(o_flit_vc);
        if (exp_q[ri].size() != 0) void'(exp_q[ri].pop_front());
        received++;
        in_pkt  <= !o_flit.tail;
        lock_vc <= o_flit_vc;
        if (fair_on) begin
          fair_prev      <= o_flit_vc;
          fair_have_prev <= 1'b1;
        end
      end
      if (!fair_on) fair_have_prev <= 1'b0;
    end
  end

  // Model outputs settle at the falling edge, ready for the next rising edge
  always @(negedge clk) begin
    int vi;
    int ui;
    vi       = onehot_to_index(o_flit_vc);
    ui       = onehot_to_index(i_flit_val);
    exp_any  = exp_q[vi].size() != 0;
    exp_head = exp_any ? exp_q[vi][0] : '0;
    exp_en   = (i_flit_val == '0) || (exp_q[ui].size() < noc_pkg::DEPTH);
    pending  = 0;
    for (int i = 0; i < noc_pkg::RADIX; i++) pending += exp_q[i].size();
  end

  // Switch ready source
  always @(posedge clk) begin
    case (ready_mode)
      0:       i_sw_ready <= 1'b0;
      1:       i_sw_ready <= 1'b1;
      default: i_sw_ready <= ($random(seed) & 3) != 0;  // Stalls about a quarter of cycles
    endcase
  end

  // Checks
  // --------------------
  a_reset : assert property (@(posedge clk) (!arst_n || after_rst) |->
    (!o_flit_val && o_flit_vc == '0 && o_en))
    else begin
      errors++;
      $display("Mismatch %s: expected val 0 vc 0 en 1, actual val %b vc %b en %b",
               test_name, o_flit_val, o_flit_vc, o_en);
    end

  a_order : assert property (@(posedge clk) disable iff (!arst_n)
    (o_flit_val && i_sw_ready) |-> (exp_any && o_flit == exp_head))
    else begin
      errors++;
      $display("Mismatch %s: vc %b expected %h actual %h", test_name, o_flit_vc,
               exp_head, o_flit);
    end

  a_lock : assert property (@(posedge clk) disable iff (!arst_n)
    in_pkt |-> (o_flit_vc == lock_vc))
    else begin
      errors++;
      $display("Packet on channel %b was interleaved with channel %b", lock_vc, o_flit_vc);
    end

  a_flow : assert property (@(posedge clk) disable iff (!arst_n)
    (|i_flit_val) |-> (o_en == exp_en))
    else begin
      errors++;
      $display("Mismatch %s: o_en expected %b actual %b", test_name, exp_en, o_en);
    end

  a_back : assert property (@(posedge clk) disable iff (!arst_n)
    (o_flit_val && !i_sw_ready) |=> ($stable(o_flit) && $stable(o_flit_vc)))
    else begin
      errors++;
      $display("Switch output changed while the switch was stalled in %s", test_name);
    end

  a_fair : assert property (@(posedge clk) disable iff (!arst_n)
    (fair_on && fair_have_prev && o_flit_val && i_sw_ready) |->
    (o_flit_vc == rotate_up(fair_prev)))
    else begin
      errors++;
      $display("Mismatch %s: vc expected %b actual %b", test_name, rotate_up(fair_prev),
               o_flit_vc);
    end

  a_end : assert property (@(posedge clk) end_chk |-> pending == 0)
    else begin
      errors++;
      $display("%0d flits never reached the switch", pending);
    end

  // Stimulus
  // --------------------

  // Offer one flit and return once it will be taken at the next rising edge
  task automatic send_flit(input int ch, input logic tail, input logic [15:0] data);
    @(posedge clk);
    i_flit     <= {tail, data};
    i_flit_val <= noc_pkg::vc_vec_t'(1) << ch;
    do @(negedge clk); while (!o_en);
  endtask

  task automatic send_packet(input int ch, input int len);
    for (int f = 0; f < len; f++) begin
      send_flit(ch, f == len - 1, {4'(ch), 12'(seq)});  // Channel and sequence in payload
      seq++;
    end
  endtask

  // Stop offering, open the switch and wait for the channels to empty
  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    i_flit_val <= '0;
    ready_mode <= 1;
    repeat (3) @(posedge clk);
    while (pending != 0 && n < 400) begin
      @(posedge clk);
      n++;
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int ch;
    int len;
    i_flit     = '0;
    i_flit_val = '0;
    wait (arst_n === 1'b1);

    // Fill each channel with the switch stalled, then offer it one flit more
    test_name = "flow";
    for (int c = 0; c < noc_pkg::RADIX; c++) begin
      ready_mode <= 0;
      send_packet(c, noc_pkg::DEPTH);
      @(posedge clk);
      i_flit     <= {1'b1, 4'(c), 12'(seq)};
      i_flit_val <= noc_pkg::vc_vec_t'(1) << c;
      seq++;
      repeat (4) @(posedge clk);  // Refused while full
      ready_mode <= 1;
      do @(negedge clk); while (!o_en);
      drain();
    end

    // Single-flit packets queued everywhere before the switch opens
    test_name = "fairness";
    ready_mode <= 0;
    fair_on    <= 1'b1;
    repeat (2) @(posedge clk);
    for (int c = 0; c < noc_pkg::RADIX; c++) begin
      for (int k = 0; k < noc_pkg::DEPTH; k++) send_packet(c, 1);
    end
    drain();
    fair_on <= 1'b0;

    test_name  = "random";
    ready_mode <= 2;
    for (int p = 0; p < N_PKT; p++) begin
      ch  = int'($unsigned($random(seed)) % noc_pkg::RADIX);
      len = 1 + int'($unsigned($random(seed)) % 4);
      send_packet(ch, len);
    end
    drain();

    @(posedge clk);
    end_chk <= 1'b1;
    @(posedge clk);
    end_chk <= 1'b0;
    @(negedge clk);
    $display("Summary: %0d errors, %0d flits sent, %0d flits received", errors, sent,
             received);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles: %0d errors, %0d flits sent, %0d received",
               cycles, errors, sent, received);
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

//--- src.f
noc_pkg.sv
pkt_fifo.sv
virtual_channel.sv
vc_arbiter.sv
input_unit.sv
tb_clock_gen.sv
input_unit_tb.sv

//--- Makefile
# Verilator build and run for the input unit testbench

TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = input_unit_tb
FLIST = src.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

# Run and decide on the pass message in the log
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
